/* Makefile */
VERILATOR ?= verilator
TOP       ?= block_reorder_tb
FILELIST  ?= block_reorder_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* block_reorder_top.f */
hdl/reorder_pkg.sv
hdl/block_if.sv
hdl/deser_control.sv
hdl/deserializer.sv
hdl/bit_reverse_stage.sv
hdl/serializer.sv
hdl/block_reorder_top.sv
tb/block_reorder_checker.sv
tb/block_reorder_tb.sv

/* hdl/bit_reverse_stage.sv */
`timescale 1ns/1ps

module bit_reverse_stage #(
  parameter int N_SAMPLES = reorder_pkg::default_n_samples,
  parameter int BIT_WIDTH = reorder_pkg::default_bit_width
) (
  input  logic  clk,
  input  logic  reset,
  block_if.sink up,
  block_if.source down
);

  import reorder_pkg::*;

  localparam int idx_w = $clog2(N_SAMPLES);

  logic                 full;
  logic                 accept;
  logic                 release_blk;
  logic [BIT_WIDTH-1:0] stored [N_SAMPLES];

  assign release_blk = down.val & down.rdy;
  // room now, or room freed by this cycle's output transfer.
  assign up.rdy      = ~full | release_blk;
  assign accept      = up.val & up.rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (release_blk) begin
      full <= 1'b0;
    end
  end

  // stored slot k takes input slot rev(k).
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int k = 0; k < N_SAMPLES; k++) begin
        stored[k] <= up.msg[rev_index(k, idx_w)];
      end
    end
  end

  assign down.val = full;
  assign down.msg = stored;

endmodule

/* hdl/block_if.sv */
`timescale 1ns/1ps

interface block_if #(
  parameter int N_SAMPLES = reorder_pkg::default_n_samples,
  parameter int BIT_WIDTH = reorder_pkg::default_bit_width
) ();

  // one whole block moves per val/rdy transfer.
  logic                 val;
  logic                 rdy;
  logic [BIT_WIDTH-1:0] msg [N_SAMPLES];

  modport source (
    output val,
    output msg,
    input  rdy
  );

  modport sink (
    input  val,
    input  msg,
    output rdy
  );

endinterface

/* hdl/block_reorder_top.sv */
`timescale 1ns/1ps

module block_reorder_top #(
  parameter int N_SAMPLES = reorder_pkg::default_n_samples,
  parameter int BIT_WIDTH = reorder_pkg::default_bit_width
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_val,
  output logic                 in_rdy,
  input  logic [BIT_WIDTH-1:0] in_data,
  output logic                 out_val,
  input  logic                 out_rdy,
  output logic [BIT_WIDTH-1:0] out_data
);

  // deserializer to bit-reverse stage.
  block_if #(
    .N_SAMPLES(N_SAMPLES),
    .BIT_WIDTH(BIT_WIDTH)
  ) blk_deser ();

  // bit-reverse stage to serializer.
  block_if #(
    .N_SAMPLES(N_SAMPLES),
    .BIT_WIDTH(BIT_WIDTH)
  ) blk_rev ();

  deserializer #(
    .N_SAMPLES(N_SAMPLES),
    .BIT_WIDTH(BIT_WIDTH)
  ) u_deser (
    .clk    (clk),
    .reset  (reset),
    .in_val (in_val),
    .in_rdy (in_rdy),
    .in_data(in_data),
    .blk    (blk_deser.source)
  );

  bit_reverse_stage #(
    .N_SAMPLES(N_SAMPLES),
    .BIT_WIDTH(BIT_WIDTH)
  ) u_rev (
    .clk  (clk),
    .reset(reset),
    .up   (blk_deser.sink),
    .down (blk_rev.source)
  );

  serializer #(
    .N_SAMPLES(N_SAMPLES),
    .BIT_WIDTH(BIT_WIDTH)
  ) u_ser (
    .clk     (clk),
    .reset   (reset),
    .blk     (blk_rev.sink),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_data(out_data)
  );

endmodule

/* hdl/deser_control.sv */
`timescale 1ns/1ps

module deser_control #(
  parameter int N_SAMPLES = reorder_pkg::default_n_samples
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_val,
  input  logic                 blk_rdy,
  output logic                 in_rdy,
  output logic                 blk_val,
  output logic [N_SAMPLES-1:0] en_sel
);

  import reorder_pkg::*;

  // one extra bit so the next count can reach N_SAMPLES.
  localparam int cnt_w = $clog2(N_SAMPLES + 1);
  localparam logic [cnt_w-1:0] full_count = cnt_w'(N_SAMPLES);
  localparam logic [N_SAMPLES-1:0] one_hot_base = 1;

  seq_state_t       state;
  seq_state_t       state_next;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] count_next;

  always_comb begin
    state_next = state;
    count_next = count;
    in_rdy     = 1'b0;
    blk_val    = 1'b0;
    en_sel     = '0;
    case (state)
      fill: begin
        in_rdy = 1'b1;
        if (in_val) begin
          // current slot captures the word.
          en_sel     = one_hot_base << count;
          count_next = count + 1'b1;
          if (count_next == full_count) begin
            count_next = '0;
            state_next = hold;
          end
        end
      end
      hold: begin
        blk_val = 1'b1;
        if (blk_rdy) begin
          state_next = fill;
        end
      end
      default: begin
        state_next = fill;
        count_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fill;
      count <= '0;
    end else begin
      state <= state_next;
      count <= count_next;
    end
  end

endmodule

/* hdl/deserializer.sv */
`timescale 1ns/1ps

module deserializer #(
  parameter int N_SAMPLES = reorder_pkg::default_n_samples,
  parameter int BIT_WIDTH = reorder_pkg::default_bit_width
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_val,
  output logic                 in_rdy,
  input  logic [BIT_WIDTH-1:0] in_data,
  block_if.source              blk
);

  logic [N_SAMPLES-1:0] en_sel;
  logic [BIT_WIDTH-1:0] slots [N_SAMPLES];

  deser_control #(
    .N_SAMPLES(N_SAMPLES)
  ) ctrl (
    .clk    (clk),
    .reset  (reset),
    .in_val (in_val),
    .blk_rdy(blk.rdy),
    .in_rdy (in_rdy),
    .blk_val(blk.val),
    .en_sel (en_sel)
  );

  // at most one enable is set, so a single slot is written per cycle.
  always_ff @(posedge clk) begin
    for (int i = 0; i < N_SAMPLES; i++) begin
      if (en_sel[i]) begin
        slots[i] <= in_data;
      end
    end
  end

  // slots are frozen while the block is offered.
  assign blk.msg = slots;

endmodule

/* hdl/reorder_pkg.sv */
package reorder_pkg;

  // sequencer phases shared by the deserializer control and the serializer.
  typedef enum logic {
    fill = 1'b0,
    hold = 1'b1
  } seq_state_t;

  // default block geometry.
  localparam int default_n_samples = 8;
  localparam int default_bit_width = 32;

  // mirror the low width bits of idx, as used for the FFT input order.
  function automatic int unsigned rev_index(input int unsigned idx,
                                            input int unsigned width);
    int unsigned rev;
    int unsigned rest;
    rev  = 0;
    rest = idx;
    for (int unsigned b = 0; b < width; b++) begin
      rev  = (rev << 1) | (rest & 32'd1);
      rest = rest >> 1;
    end
    return rev;
  endfunction

endpackage

/* hdl/serializer.sv */
`timescale 1ns/1ps

module serializer #(
  parameter int N_SAMPLES = reorder_pkg::default_n_samples,
  parameter int BIT_WIDTH = reorder_pkg::default_bit_width
) (
  input  logic                 clk,
  input  logic                 reset,
  block_if.sink                blk,
  output logic                 out_val,
  input  logic                 out_rdy,
  output logic [BIT_WIDTH-1:0] out_data
);

  import reorder_pkg::*;

  localparam int idx_w = $clog2(N_SAMPLES);
  localparam logic [idx_w-1:0] last_idx = idx_w'(N_SAMPLES - 1);

  seq_state_t           state;
  logic [idx_w-1:0]     idx;
  logic [BIT_WIDTH-1:0] slots [N_SAMPLES];
  logic                 load;
  logic                 send;

  assign blk.rdy  = (state == fill);
  assign load     = blk.val & blk.rdy;
  assign out_val  = (state == hold);
  assign send     = out_val & out_rdy;
  assign out_data = slots[idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fill;
      idx   <= '0;
    end else begin
      case (state)
        fill: begin
          if (load) begin
            state <= hold;
            idx   <= '0;
          end
        end
        hold: begin
          if (send) begin
            if (idx == last_idx) begin
              // last word gone, take the next block.
              state <= fill;
              idx   <= '0;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        default: begin
          state <= fill;
          idx   <= '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      slots <= blk.msg;
    end
  end

endmodule

/* tb/block_reorder_checker.sv */
`timescale 1ns/1ps

module block_reorder_checker #(
  parameter int BIT_WIDTH = reorder_pkg::default_bit_width
) (
  input logic                 clk,
  input logic                 reset,
  input logic                 in_val,
  input logic                 in_rdy,
  input logic [BIT_WIDTH-1:0] in_data,
  input logic                 out_val,
  input logic                 out_rdy,
  input logic [BIT_WIDTH-1:0] out_data,
  input logic                 blk_pending
);

  // a stalled input word stays offered and unchanged.
  in_hold_a: assert property (@(posedge clk) disable iff (reset)
    in_val && !in_rdy |=> in_val && $stable(in_data))
    else $error("input word changed or was withdrawn while stalled");

  out_hold_a: assert property (@(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> out_val && $stable(out_data))
    else $error("output word changed or was withdrawn while stalled");

  // no output during reset nor in the cycle after it.
  out_reset_a: assert property (@(posedge clk)
    reset |-> !out_val ##1 !out_val)
    else $error("out_val high during or right after reset");

  pending_a: assert property (@(posedge clk) disable iff (reset)
    blk_pending |-> !in_rdy)
    else $error("in_rdy high while a completed block is pending");

endmodule

bind block_reorder_top block_reorder_checker #(
  .BIT_WIDTH(BIT_WIDTH)
) chk_i (
  .clk        (clk),
  .reset      (reset),
  .in_val     (in_val),
  .in_rdy     (in_rdy),
  .in_data    (in_data),
  .out_val    (out_val),
  .out_rdy    (out_rdy),
  .out_data   (out_data),
  .blk_pending(blk_deser.val)
);

/* tb/block_reorder_tb.sv */
`timescale 1ns/1ps

module block_reorder_tb;

  import reorder_pkg::*;

  localparam int n_samples = default_n_samples;
  localparam int bit_width = default_bit_width;
  localparam int idx_w = $clog2(n_samples);
  localparam int n_rows = 9;
  localparam int margin = 200;

  typedef logic [bit_width-1:0] word_t;

  // rows: single, gaps, three back-to-back, three stalled, reset mid-block.
  word_t row_base [n_rows] = '{32'h1000_0000, 32'h2000_0000, 32'h3000_0000,
                               32'h4000_0000, 32'h5000_0000, 32'h6000_0000,
                               32'h7000_0000, 32'h8000_0000, 32'h9000_0000};
  int gap_max [n_rows] = '{0, 3, 0, 0, 0, 0, 0, 0, 0};
  int stall   [n_rows] = '{0, 0, 0, 0, 0, 40, 40, 40, 0};
  int partial [n_rows] = '{0, 0, 0, 0, 0, 0, 0, 0, 5};
  // expected cycles from last input to first output, 0 when not checked.
  int latency [n_rows] = '{3, 0, 0, 0, 0, 0, 0, 0, 0};

  logic  clk;
  logic  reset;
  logic  in_val;
  logic  in_rdy;
  word_t in_data;
  logic  out_val;
  logic  out_rdy;
  word_t out_data;

  int cycle = 0;
  int checks = 0;
  int mismatches = 0;
  int other_errors = 0;
  int blocks_done = 0;
  int out_words = 0;
  int low_run = 0;
  int max_low_run = 0;
  int accept_cycle [n_rows];
  int first_out [n_rows];
  bit extra_seen;

  block_reorder_top #(
    .N_SAMPLES(n_samples),
    .BIT_WIDTH(bit_width)
  ) dut_i (
    .clk     (clk),
    .reset   (reset),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_data (in_data),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_data(out_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // words that actually cross the output port.
  always @(posedge clk) begin
    if (out_val && out_rdy) out_words <= out_words + 1;
  end

  // longest stretch of in_rdy low, seen when all stages are full.
  always @(negedge clk) begin
    if (!in_rdy) low_run = low_run + 1;
    else low_run = 0;
    if (low_run > max_low_run) max_low_run = low_run;
  end

  function automatic word_t word_of(input int r, input int k);
    return row_base[r] + word_t'(k * 32'h0001_0101);
  endfunction

  function automatic int mirror_slot(input int k);
    logic [idx_w-1:0] fwd;
    logic [idx_w-1:0] back;
    fwd = idx_w'(k);
    for (int b = 0; b < idx_w; b++) back[b] = fwd[idx_w-1-b];
    return int'(back);
  endfunction

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      mismatches++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // called on a falling edge, returns on the falling edge after the transfer.
  task automatic send_word(input word_t w, input int gap, output int when);
    in_val = 1'b0;
    repeat (gap) @(negedge clk);
    in_val  = 1'b1;
    in_data = w;
    while (in_rdy !== 1'b1) @(negedge clk);
    when = cycle;
    @(negedge clk);
    in_val = 1'b0;
  endtask

  task automatic receive_word(input int stall_cycles, output word_t w, output int when);
    out_rdy = 1'b0;
    while (out_val !== 1'b1) @(negedge clk);
    repeat (stall_cycles) @(negedge clk);
    out_rdy = 1'b1;
    w       = out_data;
    when    = cycle;
    @(negedge clk);
  endtask

  task automatic drive_rows();
    int gap;
    int when;
    for (int r = 0; r < n_rows; r++) begin
      if (partial[r] > 0) begin
        // reset only once every earlier block has left the DUT.
        wait (blocks_done == r);
        @(negedge clk);
        for (int k = 0; k < partial[r]; k++) send_word(~word_of(r, k), 0, when);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        if (out_val !== 1'b0 || in_rdy !== 1'b1) begin
          other_errors++;
          $display("after reset in row %0d, out_val is not low or in_rdy is not high", r);
        end
      end
      for (int k = 0; k < n_samples; k++) begin
        gap = (gap_max[r] > 0) ? int'($urandom % (gap_max[r] + 1)) : 0;
        send_word(word_of(r, k), gap, when);
        accept_cycle[r] = when;
      end
    end
  endtask

  task automatic collect_rows();
    word_t got;
    int    when;
    for (int r = 0; r < n_rows; r++) begin
      for (int k = 0; k < n_samples; k++) begin
        receive_word((k == 0) ? stall[r] : stall[r] / 10, got, when);
        if (k == 0) first_out[r] = when;
        check_word($sformatf("row %0d word %0d", r, k), word_of(r, mirror_slot(k)), got);
      end
      if (latency[r] > 0) begin
        check_count($sformatf("row %0d latency", r), latency[r],
                    first_out[r] - accept_cycle[r]);
      end
      blocks_done++;
    end
  endtask

  initial begin : watchdog
    int budget;
    budget = margin;
    for (int r = 0; r < n_rows; r++) begin
      budget += (n_samples * (1 + gap_max[r]) + 2 * stall[r] + partial[r] + 2) * 4;
    end
    repeat (budget) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", budget);
    $display("sim failed");
    $finish;
  end

  initial begin
    void'($urandom(39));
    reset   = 1'b1;
    in_val  = 1'b0;
    in_data = '0;
    out_rdy = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    fork
      drive_rows();
      collect_rows();
    join
    if (max_low_run < n_samples) begin
      other_errors++;
      $display("in_rdy never stayed low while all three stages were full");
    end
    extra_seen = 1'b0;
    repeat (4 * n_samples) begin
      @(negedge clk);
      if (out_val) extra_seen = 1'b1;
    end
    if (extra_seen) begin
      other_errors++;
      $display("an unexpected output word appeared after the last block");
    end
    check_count("blocks received", n_rows, out_words / n_samples);
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
